// ==== tests/camera_stimulus.txt ====
// First word is the record count; each record after it holds the key, the accept flag,
// the strobe-while-busy flag and the expected Ux Uy Uz Vx Vy Vz Wx Wy Wz
00000011
// Invalid key 3 leaves the reset basis
00000003 0 0 3f800000 00000000 00000000 00000000 3f800000 00000000 00000000 00000000 3f800000
// L about +y
00000006 1 0 3f3504f3 00000000 bf3504f3 00000000 3f800000 00000000 3f3504f3 00000000 3f3504f3
// U pressed during the stream above
00000009 0 1 3f3504f3 00000000 bf3504f3 00000000 3f800000 00000000 3f3504f3 00000000 3f3504f3
00000006 1 0 00000000 00000000 bf800000 00000000 3f800000 00000000 3f800000 00000000 00000000
// I and K about -z, with the pair order swapped
0000000a 1 0 00000000 00000000 bf800000 bf3504f3 3f3504f3 00000000 3f3504f3 3f3504f3 00000000
0000000b 1 0 00000000 00000000 bf800000 00000000 3f800000 00000000 3f800000 00000000 00000000
00000007 1 0 3f3504f3 00000000 bf3504f3 00000000 3f800000 00000000 3f3504f3 00000000 3f3504f3
// W lies between axes so O streams an unchanged basis
00000008 1 0 3f3504f3 00000000 bf3504f3 00000000 3f800000 00000000 3f3504f3 00000000 3f3504f3
0000000a 0 1 3f3504f3 00000000 bf3504f3 00000000 3f800000 00000000 3f3504f3 00000000 3f3504f3
00000007 1 0 3f800000 00000000 00000000 00000000 3f800000 00000000 00000000 00000000 3f800000
0000000e 0 0 3f800000 00000000 00000000 00000000 3f800000 00000000 00000000 00000000 3f800000
// O and U about +z
00000008 1 0 3f3504f3 bf3504f3 00000000 3f3504f3 3f3504f3 00000000 00000000 00000000 3f800000
00000009 1 0 3f800000 00000000 00000000 00000000 3f800000 00000000 00000000 00000000 3f800000
// I and K about +x
0000000a 1 0 3f800000 00000000 00000000 00000000 3f3504f3 3f3504f3 00000000 bf3504f3 3f3504f3
0000000b 1 0 3f800000 00000000 00000000 00000000 3f800000 00000000 00000000 00000000 3f800000
// J from the reset basis, then L back
00000007 1 0 3f3504f3 00000000 3f3504f3 00000000 3f800000 00000000 bf3504f3 00000000 3f3504f3
00000006 1 0 3f800000 00000000 00000000 00000000 3f800000 00000000 00000000 00000000 3f800000

// ==== project.f ====
rtl/camera_pkg.sv
rtl/plane_rotator.sv
rtl/camera_rotator.sv
rtl/key_command_decoder.sv
rtl/camera_orientation.sv
rtl/basis_streamer.sv
rtl/camera_control_top.sv
tests/camera_control_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timescale 1ns/1ps -f project.f --top-module camera_control_tb \
	-o camera_sim || exit 1
out=$(./obj_dir/camera_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "test passed" && exit 0 || exit 1

// ==== tests/camera_control_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module camera_control_tb;

	localparam int num_records = 17;
	localparam int rec_words = 3 + camera_pkg::basis_words;
	localparam int reset_cycles = 16;

	logic clk;
	logic rst;
	logic [camera_pkg::key_w-1:0] key;
	logic key_strobe;
	logic word_valid;
	logic [3:0] word_index;
	logic [camera_pkg::float_w-1:0] word_data;
	logic busy;

	// Word 0 is the record count, then one record of rec_words words per key
	logic [31:0] stim [0:num_records*rec_words];
	integer seed;

	camera_control_top i_camera_control_top (
		.clk(clk),
		.rst(rst),
		.key(key),
		.key_strobe(key_strobe),
		.word_valid(word_valid),
		.word_index(word_index),
		.word_data(word_data),
		.busy(busy)
	);

	always #10 clk = ~clk;

	task automatic stop_run();
		$display("test failed");
		$fatal(1, "stopping at the first error");
	endtask

	initial begin
		#((num_records * 20 + reset_cycles) * 20);
		$display("timeout, the run did not finish in the expected time");
		stop_run();
	end

	function automatic logic [31:0] record_field(input int r, input int f);
		return stim[1 + r * rec_words + f];
	endfunction

	// Outputs are sampled and inputs driven 2 ns after each rising edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic check_level(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("mismatch %s: got %h expected %h", name, actual, expected);
			stop_run();
		end
	endtask

	task automatic check_word(input logic [3:0] index_exp,
		input logic [camera_pkg::float_w-1:0] data_exp);
		if (word_index !== index_exp) begin
			$display("mismatch word_index: got %h expected %h", word_index, index_exp);
			stop_run();
		end
		if (word_data !== data_exp) begin
			$display("mismatch word_data at index %h: got %h expected %h",
				index_exp, word_data, data_exp);
			stop_run();
		end
	endtask

	task automatic check_idle();
		check_level("word_valid", word_valid, 1'b0);
		check_level("busy", busy, 1'b0);
	endtask

	// The key is strobed just before the call and the first word follows three edges later
	task automatic check_stream(input int r, input logic busy_key);
		logic [31:0] next_key;
		next_key = busy_key ? record_field(r + 1, 0) : 32'd0;
		next_cycle();
		key_strobe = 1'b0;
		check_idle();
		next_cycle();
		check_level("word_valid", word_valid, 1'b0);
		check_level("busy", busy, 1'b1);
		for (int i = 0; i < camera_pkg::basis_words; i++) begin
			next_cycle();
			key_strobe = 1'b0;
			check_level("word_valid", word_valid, 1'b1);
			check_level("busy", busy, 1'b1);
			check_word(4'(i), record_field(r, 3 + i));
			// A key pressed in the middle of the stream must be dropped
			if (busy_key && i == 3) begin
				key = next_key[camera_pkg::key_w-1:0];
				key_strobe = 1'b1;
			end
		end
		next_cycle();
		check_idle();
	endtask

	initial begin
		int r;
		int gap;
		logic [31:0] rec_key;
		logic busy_key;
		clk = 1'b0;
		rst = 1'b1;
		key = '0;
		key_strobe = 1'b0;
		seed = 85;
		$readmemh("tests/camera_stimulus.txt", stim);
		if (stim[0] !== num_records) begin
			$display("stimulus file is missing or holds the wrong record count");
			stop_run();
		end
		repeat (reset_cycles) next_cycle();
		rst = 1'b0;
		repeat (3) begin
			next_cycle();
			check_idle();
		end
		r = 0;
		while (r < num_records) begin
			gap = $unsigned($random(seed)) % 4;
			repeat (gap) begin
				next_cycle();
				check_idle();
			end
			rec_key = record_field(r, 0);
			key = rec_key[camera_pkg::key_w-1:0];
			key_strobe = 1'b1;
			if (record_field(r, 1) != 32'd0) begin
				busy_key = (r + 1 < num_records) && (record_field(r + 1, 2) != 32'd0);
				check_stream(r, busy_key);
				r = busy_key ? r + 2 : r + 1;
			end else begin
				next_cycle();
				key_strobe = 1'b0;
				repeat (6) begin
					next_cycle();
					check_idle();
				end
				r = r + 1;
			end
		end
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/camera_control_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module camera_control_top (
	input wire logic clk,
	input wire logic rst,
	input wire logic [camera_pkg::key_w-1:0] key,
	input wire logic key_strobe,
	output logic word_valid,
	output logic [3:0] word_index,
	output logic [camera_pkg::float_w-1:0] word_data,
	output logic busy
);

	logic cmd_valid;
	logic [1:0] cmd_axis;
	logic cmd_cw;
	logic [camera_pkg::vec_w-1:0] u;
	logic [camera_pkg::vec_w-1:0] v;
	logic [camera_pkg::vec_w-1:0] w;
	logic basis_update;

	key_command_decoder i_key_command_decoder (
		.clk(clk),
		.rst(rst),
		.key(key),
		.key_strobe(key_strobe),
		.busy(busy),
		.cmd_valid(cmd_valid),
		.cmd_axis(cmd_axis),
		.cmd_cw(cmd_cw)
	);

	camera_orientation i_camera_orientation (
		.clk(clk),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd_axis(cmd_axis),
		.cmd_cw(cmd_cw),
		.u(u),
		.v(v),
		.w(w),
		.basis_update(basis_update)
	);

	// Busy also feeds back to the decoder so keys are dropped during a stream
	basis_streamer i_basis_streamer (
		.clk(clk),
		.rst(rst),
		.basis_update(basis_update),
		.u(u),
		.v(v),
		.w(w),
		.word_valid(word_valid),
		.word_index(word_index),
		.word_data(word_data),
		.busy(busy)
	);

endmodule

`default_nettype wire

// ==== rtl/basis_streamer.sv ====
`timescale 1ns/1ps
`default_nettype none

module basis_streamer (
	input wire logic clk,
	input wire logic rst,
	input wire logic basis_update,
	input wire logic [camera_pkg::vec_w-1:0] u,
	input wire logic [camera_pkg::vec_w-1:0] v,
	input wire logic [camera_pkg::vec_w-1:0] w,
	output logic word_valid,
	output logic [3:0] word_index,
	output logic [camera_pkg::float_w-1:0] word_data,
	output logic busy
);

	logic [3*camera_pkg::vec_w-1:0] basis_flat;
	logic [camera_pkg::float_w-1:0] words [camera_pkg::basis_words];
	logic streaming;
	logic [3:0] index;
	logic last_word;

	assign basis_flat = {u, v, w};

	// Word 0 is Ux at the top of the flattened basis
	always_ff @(posedge clk) begin
		if (basis_update) begin
			for (int i = 0; i < camera_pkg::basis_words; i++) begin
				words[i] <= basis_flat[(camera_pkg::basis_words - 1 - i) * camera_pkg::float_w
					+: camera_pkg::float_w];
			end
		end
	end

	assign last_word = (index == 4'(camera_pkg::basis_words - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			streaming <= 1'b0;
			index <= 4'd0;
		end else if (basis_update) begin
			streaming <= 1'b1;
			index <= 4'd0;
		end else if (streaming) begin
			if (last_word) begin
				streaming <= 1'b0;
				index <= 4'd0;
			end else begin
				index <= index + 4'd1;
			end
		end
	end

	assign word_valid = streaming;
	assign word_index = index;
	assign word_data = words[index];

	// basis_update covers the cycle before the first word
	assign busy = streaming | basis_update;

endmodule

`default_nettype wire

// ==== rtl/camera_orientation.sv ====
`timescale 1ns/1ps
`default_nettype none

module camera_orientation (
	input wire logic clk,
	input wire logic rst,
	input wire logic cmd_valid,
	input wire logic [1:0] cmd_axis,
	input wire logic cmd_cw,
	output logic [camera_pkg::vec_w-1:0] u,
	output logic [camera_pkg::vec_w-1:0] v,
	output logic [camera_pkg::vec_w-1:0] w,
	output logic basis_update
);

	logic [camera_pkg::vec_w-1:0] u_n;
	logic [camera_pkg::vec_w-1:0] v_n;
	logic [camera_pkg::vec_w-1:0] w_n;

	camera_rotator i_camera_rotator (
		.cmd_axis(cmd_axis),
		.cmd_cw(cmd_cw),
		.u(u),
		.v(v),
		.w(w),
		.u_n(u_n),
		.v_n(v_n),
		.w_n(w_n)
	);

	// Every command loads, even when the turn leaves the basis as it was
	always_ff @(posedge clk) begin
		if (rst) begin
			u <= camera_pkg::reset_u;
			v <= camera_pkg::reset_v;
			w <= camera_pkg::reset_w;
		end else if (cmd_valid) begin
			u <= u_n;
			v <= v_n;
			w <= w_n;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			basis_update <= 1'b0;
		end else begin
			basis_update <= cmd_valid;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/key_command_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_command_decoder (
	input wire logic clk,
	input wire logic rst,
	input wire logic [camera_pkg::key_w-1:0] key,
	input wire logic key_strobe,
	input wire logic busy,
	output logic cmd_valid,
	output logic [1:0] cmd_axis,
	output logic cmd_cw
);

	logic key_in_range;
	logic accept;
	logic [1:0] axis_sel;

	assign key_in_range = (key >= camera_pkg::key_l) && (key <= camera_pkg::key_k);

	// A pending command also blocks, since busy only rises one cycle later
	assign accept = key_strobe && !busy && !cmd_valid && key_in_range;

	always_comb begin
		case (key)
			camera_pkg::key_l, camera_pkg::key_j: begin
				axis_sel = camera_pkg::axis_v;
			end
			camera_pkg::key_o, camera_pkg::key_u: begin
				axis_sel = camera_pkg::axis_w;
			end
			camera_pkg::key_i, camera_pkg::key_k: begin
				axis_sel = camera_pkg::axis_u;
			end
			default: begin
				axis_sel = camera_pkg::axis_v;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cmd_axis <= axis_sel;
			cmd_cw <= ~key[0];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/camera_rotator.sv ====
`timescale 1ns/1ps
`default_nettype none

module camera_rotator (
	input wire logic [1:0] cmd_axis,
	input wire logic cmd_cw,
	input wire logic [camera_pkg::vec_w-1:0] u,
	input wire logic [camera_pkg::vec_w-1:0] v,
	input wire logic [camera_pkg::vec_w-1:0] w,
	output logic [camera_pkg::vec_w-1:0] u_n,
	output logic [camera_pkg::vec_w-1:0] v_n,
	output logic [camera_pkg::vec_w-1:0] w_n
);

	// Component index 0 is x, 1 is y and 2 is z
	function automatic logic [camera_pkg::float_w-1:0] get_comp(
		input logic [camera_pkg::vec_w-1:0] vec,
		input logic [1:0] idx
	);
		return vec[(2 - idx) * camera_pkg::float_w +: camera_pkg::float_w];
	endfunction

	function automatic logic [camera_pkg::vec_w-1:0] put_comp(
		input logic [camera_pkg::vec_w-1:0] vec,
		input logic [1:0] idx,
		input logic [camera_pkg::float_w-1:0] val
	);
		logic [camera_pkg::vec_w-1:0] res;
		res = vec;
		res[(2 - idx) * camera_pkg::float_w +: camera_pkg::float_w] = val;
		return res;
	endfunction

	logic [camera_pkg::vec_w-1:0] fixed_vec;
	logic [camera_pkg::vec_w-1:0] vec_a;
	logic [camera_pkg::vec_w-1:0] vec_b;
	logic axis_ok;
	logic aligned;
	logic [2:0] dir;
	logic [1:0] idx_a;
	logic [1:0] idx_b;
	logic [camera_pkg::float_w-1:0] x_0, y_0, x_n_0, y_n_0;
	logic [camera_pkg::float_w-1:0] x_1, y_1, x_n_1, y_n_1;
	logic [camera_pkg::vec_w-1:0] rot_a;
	logic [camera_pkg::vec_w-1:0] rot_b;

	always_comb begin
		axis_ok = 1'b1;
		fixed_vec = v;
		vec_a = w;
		vec_b = u;
		case (cmd_axis)
			camera_pkg::axis_v: begin
				fixed_vec = v;
				vec_a = w;
				vec_b = u;
			end
			camera_pkg::axis_w: begin
				fixed_vec = w;
				vec_a = u;
				vec_b = v;
			end
			camera_pkg::axis_u: begin
				fixed_vec = u;
				vec_a = v;
				vec_b = w;
			end
			default: axis_ok = 1'b0;
		endcase
	end

	// Signed world axis of the fixed vector, 0 to 5 for +x, -x, +y, -y, +z, -z
	always_comb begin
		aligned = 1'b1;
		dir = 3'd0;
		case (fixed_vec)
			{camera_pkg::fp_1, camera_pkg::fp_0, camera_pkg::fp_0}: dir = 3'd0;
			{camera_pkg::fp_n1, camera_pkg::fp_0, camera_pkg::fp_0}: dir = 3'd1;
			{camera_pkg::fp_0, camera_pkg::fp_1, camera_pkg::fp_0}: dir = 3'd2;
			{camera_pkg::fp_0, camera_pkg::fp_n1, camera_pkg::fp_0}: dir = 3'd3;
			{camera_pkg::fp_0, camera_pkg::fp_0, camera_pkg::fp_1}: dir = 3'd4;
			{camera_pkg::fp_0, camera_pkg::fp_0, camera_pkg::fp_n1}: dir = 3'd5;
			default: aligned = 1'b0;
		endcase
	end

	// Plane table, the negative axes swap the pair order of the positive ones
	always_comb begin
		{idx_a, idx_b} = {2'd0, 2'd1};
		case ({cmd_axis, dir})
			{camera_pkg::axis_v, 3'd0}: {idx_a, idx_b} = {2'd1, 2'd2};
			{camera_pkg::axis_v, 3'd1}: {idx_a, idx_b} = {2'd2, 2'd1};
			{camera_pkg::axis_v, 3'd2}: {idx_a, idx_b} = {2'd0, 2'd2};
			{camera_pkg::axis_v, 3'd3}: {idx_a, idx_b} = {2'd2, 2'd0};
			{camera_pkg::axis_v, 3'd4}: {idx_a, idx_b} = {2'd1, 2'd0};
			{camera_pkg::axis_v, 3'd5}: {idx_a, idx_b} = {2'd0, 2'd1};
			{camera_pkg::axis_w, 3'd0}: {idx_a, idx_b} = {2'd2, 2'd1};
			{camera_pkg::axis_w, 3'd1}: {idx_a, idx_b} = {2'd1, 2'd2};
			{camera_pkg::axis_w, 3'd2}: {idx_a, idx_b} = {2'd0, 2'd2};
			{camera_pkg::axis_w, 3'd3}: {idx_a, idx_b} = {2'd2, 2'd0};
			{camera_pkg::axis_w, 3'd4}: {idx_a, idx_b} = {2'd0, 2'd1};
			{camera_pkg::axis_w, 3'd5}: {idx_a, idx_b} = {2'd1, 2'd0};
			{camera_pkg::axis_u, 3'd0}: {idx_a, idx_b} = {2'd2, 2'd1};
			{camera_pkg::axis_u, 3'd1}: {idx_a, idx_b} = {2'd1, 2'd2};
			{camera_pkg::axis_u, 3'd2}: {idx_a, idx_b} = {2'd2, 2'd0};
			{camera_pkg::axis_u, 3'd3}: {idx_a, idx_b} = {2'd0, 2'd2};
			{camera_pkg::axis_u, 3'd4}: {idx_a, idx_b} = {2'd0, 2'd1};
			{camera_pkg::axis_u, 3'd5}: {idx_a, idx_b} = {2'd1, 2'd0};
			default: {idx_a, idx_b} = {2'd0, 2'd1};
		endcase
	end

	assign x_0 = get_comp(vec_a, idx_a);
	assign y_0 = get_comp(vec_a, idx_b);
	assign x_1 = get_comp(vec_b, idx_a);
	assign y_1 = get_comp(vec_b, idx_b);

	plane_rotator i_plane_rotator_a (
		.cw(cmd_cw),
		.x(x_0),
		.y(y_0),
		.x_n(x_n_0),
		.y_n(y_n_0)
	);

	plane_rotator i_plane_rotator_b (
		.cw(cmd_cw),
		.x(x_1),
		.y(y_1),
		.x_n(x_n_1),
		.y_n(y_n_1)
	);

	always_comb begin
		rot_a = put_comp(put_comp(vec_a, idx_a, x_n_0), idx_b, y_n_0);
		rot_b = put_comp(put_comp(vec_b, idx_a, x_n_1), idx_b, y_n_1);
		u_n = u;
		v_n = v;
		w_n = w;
		if (axis_ok && aligned) begin
			case (cmd_axis)
				camera_pkg::axis_v: begin
					w_n = rot_a;
					u_n = rot_b;
				end
				camera_pkg::axis_w: begin
					u_n = rot_a;
					v_n = rot_b;
				end
				default: begin
					v_n = rot_a;
					w_n = rot_b;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/plane_rotator.sv ====
`timescale 1ns/1ps
`default_nettype none

// Steps a unit (x, y) pair one 45 degree point around the circle
module plane_rotator (
	input wire logic cw,
	input wire logic [camera_pkg::float_w-1:0] x,
	input wire logic [camera_pkg::float_w-1:0] y,
	output logic [camera_pkg::float_w-1:0] x_n,
	output logic [camera_pkg::float_w-1:0] y_n
);

	logic [2*camera_pkg::float_w-1:0] pair;
	logic [2*camera_pkg::float_w-1:0] pair_n;

	assign pair = {x, y};
	assign x_n = pair_n[2*camera_pkg::float_w-1:camera_pkg::float_w];
	assign y_n = pair_n[camera_pkg::float_w-1:0];

	always_comb begin
		if (cw) begin
			case (pair)
				{camera_pkg::fp_0, camera_pkg::fp_1}: pair_n = {camera_pkg::fp_r2, camera_pkg::fp_r2};
				{camera_pkg::fp_r2, camera_pkg::fp_r2}: pair_n = {camera_pkg::fp_1, camera_pkg::fp_0};
				{camera_pkg::fp_1, camera_pkg::fp_0}: pair_n = {camera_pkg::fp_r2, camera_pkg::fp_nr2};
				{camera_pkg::fp_r2, camera_pkg::fp_nr2}: pair_n = {camera_pkg::fp_0, camera_pkg::fp_n1};
				{camera_pkg::fp_0, camera_pkg::fp_n1}: begin
					pair_n = {camera_pkg::fp_nr2, camera_pkg::fp_nr2};
				end
				{camera_pkg::fp_nr2, camera_pkg::fp_nr2}: begin
					pair_n = {camera_pkg::fp_n1, camera_pkg::fp_0};
				end
				{camera_pkg::fp_n1, camera_pkg::fp_0}: pair_n = {camera_pkg::fp_nr2, camera_pkg::fp_r2};
				{camera_pkg::fp_nr2, camera_pkg::fp_r2}: pair_n = {camera_pkg::fp_0, camera_pkg::fp_1};
				default: pair_n = {camera_pkg::fp_0, camera_pkg::fp_0};
			endcase
		end else begin
			case (pair)
				{camera_pkg::fp_0, camera_pkg::fp_1}: pair_n = {camera_pkg::fp_nr2, camera_pkg::fp_r2};
				{camera_pkg::fp_r2, camera_pkg::fp_r2}: pair_n = {camera_pkg::fp_0, camera_pkg::fp_1};
				{camera_pkg::fp_1, camera_pkg::fp_0}: pair_n = {camera_pkg::fp_r2, camera_pkg::fp_r2};
				{camera_pkg::fp_r2, camera_pkg::fp_nr2}: pair_n = {camera_pkg::fp_1, camera_pkg::fp_0};
				{camera_pkg::fp_0, camera_pkg::fp_n1}: pair_n = {camera_pkg::fp_r2, camera_pkg::fp_nr2};
				{camera_pkg::fp_nr2, camera_pkg::fp_nr2}: begin
					pair_n = {camera_pkg::fp_0, camera_pkg::fp_n1};
				end
				{camera_pkg::fp_n1, camera_pkg::fp_0}: begin
					pair_n = {camera_pkg::fp_nr2, camera_pkg::fp_nr2};
				end
				{camera_pkg::fp_nr2, camera_pkg::fp_r2}: pair_n = {camera_pkg::fp_n1, camera_pkg::fp_0};
				default: pair_n = {camera_pkg::fp_0, camera_pkg::fp_0};
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/camera_pkg.sv ====
`default_nettype none

package camera_pkg;

	localparam int float_w = 32;
	localparam int vec_w = 3 * float_w;

	// IEEE-754 single encodings, the only component values a unit basis can take here
	localparam logic [float_w-1:0] fp_0 = 32'h0000_0000;
	localparam logic [float_w-1:0] fp_1 = 32'h3F80_0000;
	localparam logic [float_w-1:0] fp_n1 = 32'hBF80_0000;
	localparam logic [float_w-1:0] fp_r2 = 32'h3F35_04F3;
	localparam logic [float_w-1:0] fp_nr2 = 32'hBF35_04F3;

	// Keypad codes, an even code turns clockwise
	localparam int key_w = 4;
	localparam logic [key_w-1:0] key_l = 4'd6;
	localparam logic [key_w-1:0] key_j = 4'd7;
	localparam logic [key_w-1:0] key_o = 4'd8;
	localparam logic [key_w-1:0] key_u = 4'd9;
	localparam logic [key_w-1:0] key_i = 4'd10;
	localparam logic [key_w-1:0] key_k = 4'd11;

	// Axis held fixed during a turn
	localparam logic [1:0] axis_v = 2'd1;
	localparam logic [1:0] axis_w = 2'd2;
	localparam logic [1:0] axis_u = 2'd3;

	// Ux, Uy, Uz, Vx, Vy, Vz, Wx, Wy, Wz
	localparam int basis_words = 9;

	// Vectors pack x in the top word and z in the low word
	localparam logic [vec_w-1:0] reset_u = {fp_1, fp_0, fp_0};
	localparam logic [vec_w-1:0] reset_v = {fp_0, fp_1, fp_0};
	localparam logic [vec_w-1:0] reset_w = {fp_0, fp_0, fp_1};

endpackage

`default_nettype wire
